// ==== common/dispatch_pkg.sv ====
// Dispatch unit shared definitions: memory geometry, operation, entry and result types.
package dispatch_pkg;

   localparam int DISP_ADDR_W = 11;                // Dispatch memory address width.
   localparam int DISP_DEPTH  = 1 << DISP_ADDR_W;  // 2048 entries.
   localparam int DISP_WORD_W = 17;                // Entry width.
   localparam int SRC_W       = 32;                // Source word width.
   localparam int UPC_W       = 14;                // Micro-PC width.
   localparam int ROT_W       = 5;                 // Rotate amount, 0 to 31.
   localparam int FIELD_W     = 3;                 // Field width code, 0 to 7 bits.

   // Dispatch operation carried with a start strobe.
   typedef struct packed {
      logic [ROT_W-1:0]       rot;                 // Left rotate of the source.
      logic [FIELD_W-1:0]     width;               // Number of low bits kept.
      logic [DISP_ADDR_W-1:0] base;                // Dispatch table base.
   } disp_op_t;

   // Memory entry layout, flags in the top three bits.
   typedef struct packed {
      logic             pop;                       // Bit 16.
      logic             push;                      // Bit 15.
      logic             inhibit;                   // Bit 14.
      logic [UPC_W-1:0] target;
   } disp_entry_t;

   // Decoded dispatch result handed back to the sequencer.
   typedef struct packed {
      logic [UPC_W-1:0] next_upc;
      logic             push;                      // Push return address.
      logic             pop;                       // Pop return address.
      logic             inhibit;                   // Inhibit next instruction.
   } disp_result_t;

endpackage

// ==== dispatch/dispatch_decode.sv ====
// Dispatch entry decode: picks the next micro-PC and the return stack flags.
module dispatch_decode
(
   input  logic                           clk_a,
   input  logic                           reset,
   input  logic                           entry_valid,
   input  dispatch_pkg::disp_entry_t      entry,
   input  logic [dispatch_pkg::UPC_W-1:0] entry_return_upc,
   output logic                           dispatch_valid,
   output dispatch_pkg::disp_result_t     result
);

   import dispatch_pkg::*;

   logic             entry_valid_q;
   logic [UPC_W-1:0] return_upc_q;
   disp_result_t     next_result;

   // The memory adds one cycle, so valid and return micro-PC wait for q_a.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         entry_valid_q <= 1'b0;
      end
      else
      begin
         entry_valid_q <= entry_valid;
      end
   end

   always_ff @(posedge clk_a)
   begin
      return_upc_q <= entry_return_upc;
   end

   // Pop returns to the caller's micro-PC and overrides push.
   always_comb
   begin
      next_result.inhibit = entry.inhibit;
      next_result.pop     = entry.pop;
      if (entry.pop)
      begin
         next_result.next_upc = return_upc_q;
         next_result.push     = 1'b0;
      end
      else
      begin
         next_result.next_upc = entry.target;
         next_result.push     = entry.push;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         dispatch_valid <= 1'b0;
      end
      else
      begin
         dispatch_valid <= entry_valid_q;          // One-cycle pulse per dispatch.
      end
   end

   // Result holds between dispatches.
   always_ff @(posedge clk_a)
   begin
      if (entry_valid_q)
      begin
         result <= next_result;
      end
   end

endmodule

// ==== dispatch/dispatch_field.sv ====
// Dispatch field extraction: rotates the source, masks the field and merges it into the base.
module dispatch_field
(
   input  logic                                 clk_a,
   input  logic                                 reset,
   input  logic                                 dispatch_start,
   input  dispatch_pkg::disp_op_t               dispatch_op,
   input  logic [dispatch_pkg::SRC_W-1:0]       source,
   input  logic [dispatch_pkg::UPC_W-1:0]       return_upc,
   output logic                                 addr_valid,
   output logic [dispatch_pkg::DISP_ADDR_W-1:0] disp_addr,
   output logic [dispatch_pkg::UPC_W-1:0]       stage_return_upc
);

   import dispatch_pkg::*;

   logic [2*SRC_W-1:0]     source_pair;
   logic [SRC_W-1:0]       rotated;
   logic [DISP_ADDR_W-1:0] field_mask;
   logic [DISP_ADDR_W-1:0] field_bits;
   logic [DISP_ADDR_W-1:0] next_addr;

   // Rotate left by taking a window of the doubled word.
   assign source_pair = {source, source};
   assign rotated     = source_pair[(2*SRC_W-1-dispatch_op.rot) -: SRC_W];

   // Width 0 gives an empty mask, so the base passes alone.
   assign field_mask = DISP_ADDR_W'((1 << dispatch_op.width) - 1);
   assign field_bits = rotated[DISP_ADDR_W-1:0] & field_mask;
   assign next_addr  = dispatch_op.base | field_bits;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         addr_valid <= 1'b0;
      end
      else
      begin
         addr_valid <= dispatch_start;
      end
   end

   // Address and return micro-PC move together with the valid.
   always_ff @(posedge clk_a)
   begin
      if (dispatch_start)
      begin
         disp_addr        <= next_addr;
         stage_return_upc <= return_upc;
      end
   end

endmodule

// ==== dispatch/dispatch_unit.sv ====
// Dispatch unit top: field extraction, dispatch memory and entry decode, with a host port.
module dispatch_unit
(
   input  logic                                 clk_a,
   input  logic                                 reset,
   input  logic                                 dispatch_start,
   input  dispatch_pkg::disp_op_t               dispatch_op,
   input  logic [dispatch_pkg::SRC_W-1:0]       source,
   input  logic [dispatch_pkg::UPC_W-1:0]       return_upc,
   output logic                                 dispatch_valid,
   output dispatch_pkg::disp_result_t           result,
   input  logic                                 host_wren,
   input  logic                                 host_rden,
   input  logic [dispatch_pkg::DISP_ADDR_W-1:0] host_addr,
   input  logic [dispatch_pkg::DISP_WORD_W-1:0] host_data,
   output logic [dispatch_pkg::DISP_WORD_W-1:0] host_q
);

   import dispatch_pkg::*;

   logic                   addr_valid;
   logic [DISP_ADDR_W-1:0] disp_addr;
   logic [UPC_W-1:0]       stage_return_upc;
   logic [DISP_WORD_W-1:0] q_a;

   dispatch_field u_field
   (
      .clk_a            (clk_a),
      .reset            (reset),
      .dispatch_start   (dispatch_start),
      .dispatch_op      (dispatch_op),
      .source           (source),
      .return_upc       (return_upc),
      .addr_valid       (addr_valid),
      .disp_addr        (disp_addr),
      .stage_return_upc (stage_return_upc)
   );

   // Port A is the read-only dispatch port; port B belongs to the host.
   dispatch_ram u_ram
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (disp_addr),
      .data_a    ('0),
      .wren_a    (1'b0),
      .rden_a    (addr_valid),
      .q_a       (q_a),
      .address_b (host_addr),
      .data_b    (host_data),
      .wren_b    (host_wren),
      .rden_b    (host_rden),
      .q_b       (host_q)
   );

   dispatch_decode u_decode
   (
      .clk_a            (clk_a),
      .reset            (reset),
      .entry_valid      (addr_valid),
      .entry            (disp_entry_t'(q_a)),
      .entry_return_upc (stage_return_upc),
      .dispatch_valid   (dispatch_valid),
      .result           (result)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the dispatch unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sources.f --top-module tb_dispatch_unit

# A raised error limit lets the testbench reach its own report.
output=$(./obj_dir/Vtb_dispatch_unit +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'
then
   exit 0
else
   exit 1
fi

// ==== sources.f ====
common/dispatch_pkg.sv
verilog/dispatch_ram.sv
dispatch/dispatch_field.sv
dispatch/dispatch_decode.sv
dispatch/dispatch_unit.sv
testbench/dispatch_unit_assertions.sv
testbench/tb_dispatch_unit.sv

// ==== testbench/dispatch_unit_assertions.sv ====
// Dispatch unit checker that holds a shadow memory and a latency model in concurrent assertions.
module dispatch_unit_assertions
(
   input logic                                 clk_a,
   input logic                                 reset,
   input logic                                 dispatch_start,
   input dispatch_pkg::disp_op_t               dispatch_op,
   input logic [dispatch_pkg::SRC_W-1:0]       source,
   input logic [dispatch_pkg::UPC_W-1:0]       return_upc,
   input logic                                 dispatch_valid,
   input dispatch_pkg::disp_result_t           result,
   input logic                                 host_wren,
   input logic                                 host_rden,
   input logic [dispatch_pkg::DISP_ADDR_W-1:0] host_addr,
   input logic [dispatch_pkg::DISP_WORD_W-1:0] host_data,
   input logic [dispatch_pkg::DISP_WORD_W-1:0] host_q
);

   timeunit 1ns;
   timeprecision 1ps;

   import dispatch_pkg::*;

   logic [DISP_WORD_W-1:0] shadow [0:DISP_DEPTH-1];
   logic [SRC_W-1:0]       rotated;
   logic [DISP_ADDR_W-1:0] rule_addr;
   logic                   v1;
   logic                   v2;
   logic                   v3;
   logic [DISP_ADDR_W-1:0] a1;
   logic [UPC_W-1:0]       r1;
   logic [UPC_W-1:0]       r2;
   disp_entry_t            e2;
   disp_result_t           dec;
   disp_result_t           exp3;
   logic [DISP_WORD_W-1:0] host_exp;
   int                     assert_errors = 0;

   assign rotated   = (source << dispatch_op.rot) | (source >> (SRC_W - int'(dispatch_op.rot)));
   assign rule_addr = dispatch_op.base | (rotated[DISP_ADDR_W-1:0] &
                      ((DISP_ADDR_W'(1) << dispatch_op.width) - DISP_ADDR_W'(1)));

   always_ff @(posedge clk_a)
   begin
      if (host_wren)
      begin
         shadow[host_addr] <= host_data;           // Only port B ever writes.
      end
   end

   // Start to valid is three edges; the entry is fetched at the second.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         v1       <= 1'b0;
         v2       <= 1'b0;
         v3       <= 1'b0;
         host_exp <= '0;
      end
      else
      begin
         v1 <= dispatch_start;
         v2 <= v1;
         v3 <= v2;
         if (host_rden)
         begin
            host_exp <= shadow[host_addr];
         end
      end
      a1   <= rule_addr;
      r1   <= return_upc;
      e2   <= disp_entry_t'(shadow[a1]);           // Old data if the host writes now.
      r2   <= r1;
      exp3 <= dec;
   end

   always_comb
   begin
      dec.pop      = e2.pop;
      dec.inhibit  = e2.inhibit;
      dec.push     = e2.push && !e2.pop;
      dec.next_upc = e2.pop ? r2 : e2.target;
   end

   a_valid_latency: assert property (@(posedge clk_a) disable iff (reset)
      dispatch_valid == v3)
   else
   begin
      assert_errors = assert_errors + 1;
      $error("dispatch_valid off the start latency");
   end

   a_result: assert property (@(posedge clk_a) disable iff (reset)
      dispatch_valid |-> result == exp3)
   else
   begin
      assert_errors = assert_errors + 1;
      $error("result differs from shadow entry");
   end

   a_pop_push: assert property (@(posedge clk_a) disable iff (reset)
      dispatch_valid && result.pop |-> !result.push)
   else
   begin
      assert_errors = assert_errors + 1;
      $error("push set together with pop");
   end

   a_host_q: assert property (@(posedge clk_a) disable iff (reset)
      host_q == host_exp)
   else
   begin
      assert_errors = assert_errors + 1;
      $error("host_q differs from shadow entry");
   end

endmodule

// ==== testbench/tb_dispatch_unit.sv ====
// Dispatch unit testbench with host load and readback, random dispatches and mixed-port reads.
module tb_dispatch_unit;

   timeunit 1ns;
   timeprecision 1ps;

   import dispatch_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;          // About twice the test length.

   logic                   clk_a;
   logic                   reset;
   logic                   dispatch_start;
   disp_op_t               dispatch_op;
   logic [SRC_W-1:0]       source;
   logic [UPC_W-1:0]       return_upc;
   logic                   dispatch_valid;
   disp_result_t           result;
   logic                   host_wren;
   logic                   host_rden;
   logic [DISP_ADDR_W-1:0] host_addr;
   logic [DISP_WORD_W-1:0] host_data;
   logic [DISP_WORD_W-1:0] host_q;

   logic [31:0]            lfsr_state = 32'h9c04_df70;
   logic [DISP_WORD_W-1:0] tb_mem [0:DISP_DEPTH-1];
   logic [DISP_ADDR_W-1:0] addr_list [0:255];
   disp_result_t           exp_q [$];
   disp_result_t           expected_res;
   int                     error_count = 0;
   int                     cycle_count = 0;

   dispatch_unit u_dut
   (
      .clk_a          (clk_a),
      .reset          (reset),
      .dispatch_start (dispatch_start),
      .dispatch_op    (dispatch_op),
      .source         (source),
      .return_upc     (return_upc),
      .dispatch_valid (dispatch_valid),
      .result         (result),
      .host_wren      (host_wren),
      .host_rden      (host_rden),
      .host_addr      (host_addr),
      .host_data      (host_data),
      .host_q         (host_q)
   );

   bind dispatch_unit dispatch_unit_assertions u_chk
   (
      .clk_a (clk_a), .reset (reset), .dispatch_start (dispatch_start),
      .dispatch_op (dispatch_op), .source (source), .return_upc (return_upc),
      .dispatch_valid (dispatch_valid), .result (result), .host_wren (host_wren),
      .host_rden (host_rden), .host_addr (host_addr), .host_data (host_data),
      .host_q (host_q)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #20 clk_a = ~clk_a;
   end

   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic feedback;
      feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], feedback};
   endfunction

   task automatic take_bits(input int count, output logic [31:0] bits);
      int k;
      bits = '0;
      for (k = 0; k < count; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};
      end
   endtask

   // Bit i of the field is source bit (i - rot) mod 32.
   function automatic logic [DISP_ADDR_W-1:0] expected_addr(input disp_op_t op,
                                                          input logic [31:0] src);
      logic [DISP_ADDR_W-1:0] addr;
      int                     i;
      addr = op.base;
      for (i = 0; i < int'(op.width); i++)
      begin
         addr[i] = addr[i] | src[(i - int'(op.rot) + 32) % 32];
      end
      return addr;
   endfunction

   function automatic disp_result_t expected_result(input disp_entry_t e,
                                                    input logic [UPC_W-1:0] rupc);
      disp_result_t r;
      r.pop      = e.pop;
      r.inhibit  = e.inhibit;
      r.push     = e.pop ? 1'b0 : e.push;
      r.next_upc = e.pop ? rupc : e.target;
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         error_count++;
         $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_a);
      #2;
   endtask

   task automatic idle_cycles(input int count);
      dispatch_start = 1'b0;
      host_wren      = 1'b0;
      host_rden      = 1'b0;
      repeat (count) next_cycle();
   endtask

   task automatic issue_dispatch(input disp_op_t op, input logic [31:0] src,
                                 input logic [UPC_W-1:0] rupc);
      logic [DISP_ADDR_W-1:0] addr;
      addr = expected_addr(op, src);
      exp_q.push_back(expected_result(disp_entry_t'(tb_mem[addr]), rupc));
      dispatch_start = 1'b1;
      dispatch_op    = op;
      source         = src;
      return_upc     = rupc;
      next_cycle();
   endtask

   // Results must come back in issue order.
   always @(negedge clk_a)
   begin
      if (!reset && dispatch_valid)
      begin
         if (exp_q.size() == 0)
         begin
            error_count++;
            $display("dispatch_valid high at %0t with no dispatch outstanding", $time);
         end
         else
         begin
            expected_res = exp_q.pop_front();
            check_value("result", 32'(expected_res), 32'(result));
         end
      end
   end

   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk_a);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, the run did not finish", cycle_count);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      logic [31:0]            bits;
      logic [3:0]             blk0;
      logic [3:0]             blk1;
      logic [6:0]             start_off;
      disp_op_t               op;
      logic [31:0]            src;
      logic [DISP_ADDR_W-1:0] mix_addr;
      int                     i;
      $timeformat(-9, 0, " ns", 0);
      reset          = 1'b1;
      dispatch_start = 1'b0;
      dispatch_op    = '0;
      source         = '0;
      return_upc     = '0;
      host_wren      = 1'b0;
      host_rden      = 1'b0;
      host_addr      = '0;
      host_data      = '0;
      repeat (2) @(posedge clk_a);
      #2;
      reset = 1'b0;
      next_cycle();
      check_value("dispatch_valid", 32'(0), 32'(dispatch_valid));
      check_value("host_q", 32'(0), 32'(host_q));

      // Two distinct 128-entry blocks keep every dispatch on a loaded entry.
      take_bits(4, bits);
      blk0 = bits[3:0];
      take_bits(3, bits);
      blk1 = blk0 ^ 4'(int'(bits[2:0]) + 1);
      take_bits(7, bits);
      start_off = bits[6:0];
      for (i = 0; i < 256; i++)
      begin
         addr_list[i] = {(i % 2 == 1) ? blk1 : blk0, 7'((i / 2) * 45 + int'(start_off))};
         take_bits(DISP_WORD_W, bits);
         host_wren = 1'b1;
         host_addr = addr_list[i];
         host_data = bits[DISP_WORD_W-1:0];
         tb_mem[addr_list[i]] = bits[DISP_WORD_W-1:0];
         next_cycle();
      end
      host_wren = 1'b0;
      for (i = 255; i >= 0; i--)
      begin
         host_rden = 1'b1;
         host_addr = addr_list[i];
         next_cycle();
         check_value("host_q", 32'(tb_mem[addr_list[i]]), 32'(host_q));
      end
      host_rden = 1'b0;

      for (i = 0; i < 300; i++)
      begin
         take_bits(8, bits);
         op.base = {bits[7] ? blk1 : blk0, bits[6:0]};
         take_bits(ROT_W, bits);
         op.rot = bits[ROT_W-1:0];
         take_bits(FIELD_W, bits);
         op.width = bits[FIELD_W-1:0];
         if (i % 10 == 0) op.width = '0;
         if (i % 10 == 1) op.rot = '0;
         if (i % 10 == 2) op.rot = 5'd31;
         take_bits(32, src);
         take_bits(UPC_W, bits);
         issue_dispatch(op, src, bits[UPC_W-1:0]);
         take_bits(2, bits);
         if (bits[1:0] == 2'b11)
         begin
            take_bits(2, bits);
            idle_cycles(int'(bits[1:0]) + 1);       // Isolated starts.
         end
      end
      idle_cycles(4);

      // The host write lands on the edge where port A reads the same entry.
      mix_addr = addr_list[0];
      op.base  = mix_addr;
      op.rot   = '0;
      op.width = '0;
      issue_dispatch(op, 32'h0, 14'h1234);
      dispatch_start = 1'b0;
      host_wren = 1'b1;
      host_addr = mix_addr;
      host_data = ~tb_mem[mix_addr];
      tb_mem[mix_addr] = ~tb_mem[mix_addr];
      next_cycle();
      host_wren = 1'b0;
      issue_dispatch(op, 32'h0, 14'h2345);
      idle_cycles(1);

      while (exp_q.size() != 0) next_cycle();
      idle_cycles(4);
      $display("Errors: %0d value mismatches, %0d assertion failures",
               error_count, u_dut.u_chk.assert_errors);
      if (error_count == 0 && u_dut.u_chk.assert_errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== verilog/dispatch_ram.sv ====
// Dual-port 2Kx17 dispatch memory with registered, read-enabled outputs on one clock.
module dispatch_ram
(
   input  logic                               clk_a,
   input  logic                               reset,
   input  logic [dispatch_pkg::DISP_ADDR_W-1:0] address_a,
   input  logic [dispatch_pkg::DISP_WORD_W-1:0] data_a,
   input  logic                               wren_a,
   input  logic                               rden_a,
   output logic [dispatch_pkg::DISP_WORD_W-1:0] q_a,
   input  logic [dispatch_pkg::DISP_ADDR_W-1:0] address_b,
   input  logic [dispatch_pkg::DISP_WORD_W-1:0] data_b,
   input  logic                               wren_b,
   input  logic                               rden_b,
   output logic [dispatch_pkg::DISP_WORD_W-1:0] q_b
);

   import dispatch_pkg::*;

   logic [DISP_WORD_W-1:0] mem [0:DISP_DEPTH-1];

   // Single write process; port A has priority.
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         mem[address_a] <= data_a;
      end
      else if (wren_b)
      begin
         mem[address_b] <= data_b;
      end
   end

   // Port A read register. Reads the array before any same-edge write lands.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= mem[address_a];                    // Old data on a mixed-port write.
      end
   end

   // Port B read register, holds until the next read.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= mem[address_b];
      end
   end

endmodule
